//--- flist.f
+incdir+src
src/rv_op_pkg.sv
src/mem_access_pkg.sv
src/ls_dispatch.sv
src/ls_buffer.sv
src/data_mem.sv
src/ls_unit_top.sv
sim/tb_ls_unit.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_ls_unit -o sim_ls_unit
./obj_dir/sim_ls_unit 2>&1 | tee sim.log

if grep -q "all tests passed" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

//--- sim/tb_ls_unit.sv
`timescale 1ns/10ps
`include "lsq_macros.svh"

module tb_ls_unit;
    localparam int TW = `LSQ_TAG_W;
    localparam int DW = `LSQ_DATA_W;
    localparam int IW = `LSQ_IMM_W;
    localparam int NTAGS = 1 << TW;
    localparam int MEM_BYTES = 4 * `LSQ_MEM_WORDS;
    localparam int BA_W = $clog2(MEM_BYTES);
    localparam int NUM_RANDOM = 200;
    // directed operations plus the random mix
    localparam int NUM_OPS = NUM_RANDOM + 70;
    localparam int WATCHDOG_CYCLES = NUM_OPS * 40;

    logic              clk;
    logic              arst_n;
    logic              disp_en;
    rv_op_pkg::ls_op_e disp_op;
    logic [IW-1:0]     disp_imm;
    logic [TW-1:0]     disp_tag;
    logic [TW-1:0]     disp_rs1_tag;
    logic [DW-1:0]     disp_rs1_data;
    logic [TW-1:0]     disp_rs2_tag;
    logic [DW-1:0]     disp_rs2_data;
    logic              ex_en;
    logic [TW-1:0]     ex_tag;
    logic [DW-1:0]     ex_data;
    logic              commit_en;
    logic [TW-1:0]     commit_tag;
    logic              cdb_en;
    logic [TW-1:0]     cdb_tag;
    logic [DW-1:0]     cdb_data;
    logic              full;

    // byte image of the data memory
    logic [7:0]        model [MEM_BYTES];
    logic [DW-1:0]     exp_data [NTAGS];
    int                sent_cnt [NTAGS];
    int                done_cnt [NTAGS];
    int                loads_sent;
    int                results;
    string             test_name;
    logic [31:0]       rng_state;

    ls_unit_top dut (
        .clk, .arst_n,
        .disp_en, .disp_op, .disp_imm, .disp_tag,
        .disp_rs1_tag, .disp_rs1_data, .disp_rs2_tag, .disp_rs2_data,
        .ex_en, .ex_tag, .ex_data,
        .commit_en, .commit_tag,
        .cdb_en, .cdb_tag, .cdb_data,
        .full
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [DW-1:0] sext_imm(input logic [IW-1:0] imm);
        return {{(DW - IW){imm[IW-1]}}, imm};
    endfunction

    // expected load value from the byte image, with extension
    function automatic logic [DW-1:0] ref_load(input rv_op_pkg::ls_op_e op,
                                               input logic [DW-1:0] addr);
        logic [BA_W-1:0] a;
        logic [BA_W-1:0] a1;
        logic [BA_W-1:0] a2;
        logic [BA_W-1:0] a3;
        a  = addr[BA_W-1:0];
        a1 = a + BA_W'(1);
        a2 = a + BA_W'(2);
        a3 = a + BA_W'(3);
        case (op)
            rv_op_pkg::op_lb:  return {{(DW - 8){model[a][7]}}, model[a]};
            rv_op_pkg::op_lbu: return {{(DW - 8){1'b0}}, model[a]};
            rv_op_pkg::op_lh:  return {{(DW - 16){model[a1][7]}}, model[a1], model[a]};
            rv_op_pkg::op_lhu: return {{(DW - 16){1'b0}}, model[a1], model[a]};
            default:           return {model[a3], model[a2], model[a1], model[a]};
        endcase
    endfunction

    function automatic void ref_store(input rv_op_pkg::ls_op_e op,
                                      input logic [DW-1:0] addr,
                                      input logic [DW-1:0] data);
        logic [BA_W-1:0] a;
        a = addr[BA_W-1:0];
        model[a] = data[7:0];
        if (op != rv_op_pkg::op_sb) begin
            model[a + BA_W'(1)] = data[15:8];
        end
        if (op == rv_op_pkg::op_sw) begin
            model[a + BA_W'(2)] = data[23:16];
            model[a + BA_W'(3)] = data[31:24];
        end
    endfunction

    function automatic logic busy(input logic [TW-1:0] t);
        return sent_cnt[t] != done_cnt[t];
    endfunction

    function automatic logic all_done();
        for (int t = 1; t < NTAGS; t++) begin
            if (busy(TW'(t))) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    function automatic logic [TW-1:0] free_tag();
        for (int t = 1; t < NTAGS; t++) begin
            if (!busy(TW'(t))) begin
                return TW'(t);
            end
        end
        return '0;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic dispatch(input rv_op_pkg::ls_op_e op, input logic [TW-1:0] tag,
                            input logic [TW-1:0] rs1_tag, input logic [DW-1:0] rs1_data,
                            input logic [TW-1:0] rs2_tag, input logic [DW-1:0] rs2_data,
                            input logic [IW-1:0] imm);
        @(negedge clk);
        while (full) begin
            @(negedge clk);
        end
        @(posedge clk);
        disp_en       <= 1'b1;
        disp_op       <= op;
        disp_tag      <= tag;
        disp_imm      <= imm;
        disp_rs1_tag  <= rs1_tag;
        disp_rs1_data <= rs1_data;
        disp_rs2_tag  <= rs2_tag;
        disp_rs2_data <= rs2_data;
        @(posedge clk);
        disp_en <= 1'b0;
    endtask

    // a waiting base gets junk data so only the broadcast can fix it
    task automatic send_load(input rv_op_pkg::ls_op_e op, input logic [TW-1:0] tag,
                             input logic [TW-1:0] rs1_tag, input logic [DW-1:0] base,
                             input logic [IW-1:0] imm);
        exp_data[tag] = ref_load(op, base + sext_imm(imm));
        sent_cnt[tag] = sent_cnt[tag] + 1;
        loads_sent++;
        dispatch(op, tag, rs1_tag, (rs1_tag == '0) ? base : 32'hdead_beef, '0, '0, imm);
    endtask

    task automatic send_store(input rv_op_pkg::ls_op_e op, input logic [TW-1:0] tag,
                              input logic [TW-1:0] rs2_tag, input logic [DW-1:0] base,
                              input logic [IW-1:0] imm, input logic [DW-1:0] data);
        dispatch(op, tag, '0, base, rs2_tag, (rs2_tag == '0) ? data : 32'h0bad_0bad, imm);
    endtask

    task automatic commit_store(input logic [TW-1:0] tag, input rv_op_pkg::ls_op_e op,
                                input logic [DW-1:0] addr, input logic [DW-1:0] data);
        @(posedge clk);
        commit_en  <= 1'b1;
        commit_tag <= tag;
        ref_store(op, addr, data);
        @(posedge clk);
        commit_en <= 1'b0;
    endtask

    task automatic store_now(input rv_op_pkg::ls_op_e op, input logic [TW-1:0] tag,
                             input logic [DW-1:0] base, input logic [IW-1:0] imm,
                             input logic [DW-1:0] data);
        send_store(op, tag, '0, base, imm, data);
        commit_store(tag, op, base + sext_imm(imm), data);
    endtask

    task automatic broadcast_ex(input logic [TW-1:0] tag, input logic [DW-1:0] data);
        @(posedge clk);
        ex_en   <= 1'b1;
        ex_tag  <= tag;
        ex_data <= data;
        @(posedge clk);
        ex_en <= 1'b0;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic wait_results();
        @(negedge clk);
        while (!all_done()) begin
            @(negedge clk);
        end
    endtask

    task automatic run_random_mix();
        logic [31:0]       r;
        logic [31:0]       r2;
        logic [DW-1:0]     addr;
        logic [DW-1:0]     base;
        logic [IW-1:0]     imm;
        logic [TW-1:0]     tag;
        rv_op_pkg::ls_op_e op;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            r    = next_rand();
            r2   = next_rand();
            op   = rv_op_pkg::ls_op_e'({1'b0, r[30:28]});
            addr = {{(DW - 10){1'b0}}, r[25:16]};
            imm  = r2[27:16];
            case (op)
                rv_op_pkg::op_lh, rv_op_pkg::op_lhu, rv_op_pkg::op_sh: addr[0] = 1'b0;
                rv_op_pkg::op_lw, rv_op_pkg::op_sw: addr[1:0] = 2'b00;
                default: ;
            endcase
            base = addr - sext_imm(imm);
            tag  = free_tag();
            while (tag == '0) begin
                @(negedge clk);
                tag = free_tag();
            end
            if (op == rv_op_pkg::op_sb || op == rv_op_pkg::op_sh || op == rv_op_pkg::op_sw) begin
                store_now(op, tag, base, imm, next_rand());
            end else begin
                send_load(op, tag, '0, base, imm);
            end
        end
        wait_results();
    endtask

    // every load result against the table of expected values
    always @(posedge clk) begin
        if (arst_n && cdb_en) begin
            assert (busy(cdb_tag))
                else fail_run($sformatf("result on tag %0d with no load waiting for it", cdb_tag));
            assert (cdb_data == exp_data[cdb_tag])
                else fail_run($sformatf("Mismatch in %s: tag %0d expected %h actual %h",
                                        test_name, cdb_tag, exp_data[cdb_tag], cdb_data));
            done_cnt[cdb_tag] = done_cnt[cdb_tag] + 1;
            results++;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_run("watchdog expired before all loads returned");
    end

    initial begin
        rng_state = 32'h8ec2_6562;
        for (int i = 0; i < MEM_BYTES; i++) begin
            model[i] = 8'h00;
        end
        arst_n        <= 1'b0;
        disp_en       <= 1'b0;
        disp_op       <= rv_op_pkg::op_other;
        disp_imm      <= '0;
        disp_tag      <= '0;
        disp_rs1_tag  <= '0;
        disp_rs1_data <= '0;
        disp_rs2_tag  <= '0;
        disp_rs2_data <= '0;
        ex_en         <= 1'b0;
        ex_tag        <= '0;
        ex_data       <= '0;
        commit_en     <= 1'b0;
        commit_tag    <= '0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);

        test_name = "width_sign";
        store_now(rv_op_pkg::op_sw, 4'd1, 32'h100, 12'h000, 32'h8421_f0e1);
        store_now(rv_op_pkg::op_sh, 4'd2, 32'h10a, 12'hffc, 32'h1234_9a7c);
        store_now(rv_op_pkg::op_sb, 4'd3, 32'h0f1, 12'h010, 32'h0000_0055);
        store_now(rv_op_pkg::op_sb, 4'd4, 32'h107, 12'h000, 32'hffff_ffc3);
        send_load(rv_op_pkg::op_lw, 4'd5, '0, 32'h100, 12'h000);
        send_load(rv_op_pkg::op_lh, 4'd6, '0, 32'h100, 12'h006);
        send_load(rv_op_pkg::op_lhu, 4'd7, '0, 32'h100, 12'h006);
        send_load(rv_op_pkg::op_lb, 4'd8, '0, 32'h100, 12'h007);
        send_load(rv_op_pkg::op_lbu, 4'd9, '0, 32'h100, 12'h007);
        send_load(rv_op_pkg::op_lb, 4'd10, '0, 32'h110, 12'hff1);
        send_load(rv_op_pkg::op_lhu, 4'd11, '0, 32'h100, 12'h002);
        send_load(rv_op_pkg::op_lw, 4'd12, '0, 32'h100, 12'h004);
        wait_results();

        test_name = "ex_wakeup";
        store_now(rv_op_pkg::op_sw, 4'd1, 32'h204, 12'h000, 32'h1357_9bdf);
        send_load(rv_op_pkg::op_lw, 4'd2, 4'd14, 32'h1f0, 12'h014);
        send_store(rv_op_pkg::op_sw, 4'd3, 4'd15, 32'h300, 12'h000, 32'hcafe_0042);
        commit_store(4'd3, rv_op_pkg::op_sw, 32'h300, 32'hcafe_0042);
        wait_cycles(10);
        assert (busy(4'd2))
            else fail_run("load returned a result before its base was broadcast");
        broadcast_ex(4'd14, 32'h1f0);
        broadcast_ex(4'd15, 32'hcafe_0042);
        send_load(rv_op_pkg::op_lw, 4'd4, '0, 32'h300, 12'h000);
        send_load(rv_op_pkg::op_lhu, 4'd5, '0, 32'h300, 12'h002);
        wait_results();

        test_name = "load_forward";
        store_now(rv_op_pkg::op_sw, 4'd1, 32'h080, 12'h000, 32'h0000_0340);
        store_now(rv_op_pkg::op_sb, 4'd2, 32'h348, 12'h000, 32'h0000_00a5);
        // first load held back until both dependents sit in the buffer
        send_load(rv_op_pkg::op_lw, 4'd4, 4'd13, 32'h080, 12'h000);
        send_load(rv_op_pkg::op_lb, 4'd5, 4'd4, ref_load(rv_op_pkg::op_lw, 32'h080), 12'h008);
        send_load(rv_op_pkg::op_lbu, 4'd6, 4'd4, ref_load(rv_op_pkg::op_lw, 32'h080), 12'h008);
        broadcast_ex(4'd13, 32'h080);
        wait_results();

        test_name = "commit_gate";
        // older load of the store's word, issued only after the store sat uncommitted
        send_load(rv_op_pkg::op_lw, 4'd9, 4'd13, 32'h3a0, 12'h000);
        send_store(rv_op_pkg::op_sw, 4'd6, '0, 32'h3a0, 12'h000, 32'h7777_1111);
        send_load(rv_op_pkg::op_lw, 4'd7, '0, 32'h3a4, 12'h000);
        wait_cycles(4);
        broadcast_ex(4'd13, 32'h3a0);
        wait_results();
        commit_store(4'd6, rv_op_pkg::op_sw, 32'h3a0, 32'h7777_1111);
        send_load(rv_op_pkg::op_lw, 4'd8, '0, 32'h3a0, 12'h000);
        wait_results();

        test_name = "filter_full";
        dispatch(rv_op_pkg::op_other, 4'd9, '0, 32'h100, '0, '0, 12'h000);
        // long enough for a stray result to show up
        wait_cycles(8);
        for (int t = 1; t <= 14; t++) begin
            send_load(rv_op_pkg::op_lw, TW'(t), 4'd15, 32'h100, IW'(4 * t));
        end
        @(negedge clk);
        assert (full)
            else fail_run("full stayed low with 14 loads held in the buffer");
        broadcast_ex(4'd15, 32'h100);
        wait_results();

        test_name = "random_mix";
        run_random_mix();

        if (all_done() && results == loads_sent) begin
            $display("all tests passed");
            $finish;
        end else begin
            fail_run($sformatf("%0d loads sent but %0d results seen", loads_sent, results));
        end
    end

endmodule

//--- src/data_mem.sv
`timescale 1ns/10ps
`include "lsq_macros.svh"

module data_mem (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     req_en,
    input  rv_op_pkg::ls_dir_e       req_dir,
    input  mem_access_pkg::acc_len_e req_len,
    input  logic                     req_signed,
    input  logic [`LSQ_DATA_W-1:0]   req_addr,
    input  logic [`LSQ_DATA_W-1:0]   req_wdata,
    input  logic [`LSQ_TAG_W-1:0]    req_tag,
    output logic                     rsp_en,
    output logic [`LSQ_TAG_W-1:0]    rsp_tag,
    output logic [`LSQ_DATA_W-1:0]   rsp_data
);
    localparam int DW      = `LSQ_DATA_W;
    localparam int TW      = `LSQ_TAG_W;
    localparam int WORDS   = `LSQ_MEM_WORDS;
    localparam int WORD_AW = $clog2(WORDS);
    // last delay stage feeds the read-modify-write stage
    localparam int DLY     = `LSQ_MEM_LAT - 1;
    localparam int REQ_W   = 1 + 2 + 1 + 2 * DW + TW;

    logic [DLY-1:0]     dly_en;
    logic [REQ_W-1:0]   dly_req [DLY];

    logic               s_dir, s_signed;
    logic [1:0]         s_len;
    logic [DW-1:0]      s_addr, s_wdata;
    logic [TW-1:0]      s_tag;
    logic [WORD_AW-1:0] s_idx;
    logic [1:0]         s_lane;
    logic [3:0]         lane_mask;
    logic [DW-1:0]      lane_data, old_word, new_word, shifted, load_val;

    logic [DW-1:0]      mem [WORDS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dly_en <= '0;
        end else begin
            dly_en[0] <= req_en;
            for (int i = 1; i < DLY; i++) begin
                dly_en[i] <= dly_en[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        dly_req[0] <= {req_dir, req_len, req_signed, req_addr, req_wdata, req_tag};
        for (int i = 1; i < DLY; i++) begin
            dly_req[i] <= dly_req[i-1];
        end
    end

    assign {s_dir, s_len, s_signed, s_addr, s_wdata, s_tag} = dly_req[DLY-1];
    assign s_idx    = s_addr[WORD_AW+1:2];
    assign s_lane   = s_addr[1:0];
    assign old_word = mem[s_idx];
    assign shifted  = old_word >> {s_lane, 3'b000};

    always_comb begin
        case (s_len)
            mem_access_pkg::len_byte: begin
                lane_mask = 4'b0001 << s_lane;
                lane_data = {4{s_wdata[7:0]}};
                load_val  = {{(DW - 8){s_signed & shifted[7]}}, shifted[7:0]};
            end
            mem_access_pkg::len_half: begin
                lane_mask = 4'b0011 << {s_lane[1], 1'b0};
                lane_data = {2{s_wdata[15:0]}};
                load_val  = {{(DW - 16){s_signed & shifted[15]}}, shifted[15:0]};
            end
            default: begin
                lane_mask = 4'b1111;
                lane_data = s_wdata;
                load_val  = old_word;
            end
        endcase
        for (int b = 0; b < 4; b++) begin
            new_word[8*b +: 8] = lane_mask[b] ? lane_data[8*b +: 8] : old_word[8*b +: 8];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int w = 0; w < WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (dly_en[DLY-1] && s_dir == rv_op_pkg::dir_store) begin
            mem[s_idx] <= new_word;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_en <= 1'b0;
        end else begin
            rsp_en <= dly_en[DLY-1] && s_dir == rv_op_pkg::dir_load;
        end
    end

    always_ff @(posedge clk) begin
        rsp_tag  <= s_tag;
        rsp_data <= load_val;
    end

endmodule

//--- src/ls_buffer.sv
`timescale 1ns/10ps
`include "lsq_macros.svh"

module ls_buffer (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     ent_en,
    input  logic [`LSQ_TAG_W-1:0]    ent_tag,
    input  rv_op_pkg::ls_dir_e       ent_dir,
    input  mem_access_pkg::acc_len_e ent_len,
    input  logic                     ent_signed,
    input  logic [`LSQ_IMM_W-1:0]    ent_imm,
    input  logic [`LSQ_TAG_W-1:0]    ent_rs1_tag,
    input  logic [`LSQ_DATA_W-1:0]   ent_rs1_data,
    input  logic                     ent_rs1_rdy,
    input  logic [`LSQ_TAG_W-1:0]    ent_rs2_tag,
    input  logic [`LSQ_DATA_W-1:0]   ent_rs2_data,
    input  logic                     ent_rs2_rdy,
    input  logic                     ex_en,
    input  logic [`LSQ_TAG_W-1:0]    ex_tag,
    input  logic [`LSQ_DATA_W-1:0]   ex_data,
    input  logic                     commit_en,
    input  logic [`LSQ_TAG_W-1:0]    commit_tag,
    input  logic                     rsp_en,
    input  logic [`LSQ_TAG_W-1:0]    rsp_tag,
    input  logic [`LSQ_DATA_W-1:0]   rsp_data,
    output logic                     req_en,
    output rv_op_pkg::ls_dir_e       req_dir,
    output mem_access_pkg::acc_len_e req_len,
    output logic                     req_signed,
    output logic [`LSQ_DATA_W-1:0]   req_addr,
    output logic [`LSQ_DATA_W-1:0]   req_wdata,
    output logic [`LSQ_TAG_W-1:0]    req_tag,
    output logic                     full
);
    localparam int N       = `LSQ_ENTRIES;
    localparam int TAG_W   = `LSQ_TAG_W;
    localparam int DATA_W  = `LSQ_DATA_W;
    localparam int IMM_W   = `LSQ_IMM_W;
    localparam int CNT_W   = $clog2(N + 1);
    // two slots of headroom for the dispatch register
    localparam int FULL_AT = N - 2;

    logic [N-1:0]             occ_q, iss_q, cmt_q, rs1_rdy_q, rs2_rdy_q, sgn_q;
    rv_op_pkg::ls_dir_e       dir_q [N];
    mem_access_pkg::acc_len_e len_q [N];
    logic [IMM_W-1:0]         imm_q [N];
    logic [TAG_W-1:0]         rs1_tag_q [N];
    logic [TAG_W-1:0]         rs2_tag_q [N];
    logic [DATA_W-1:0]        rs1_data_q [N];
    logic [DATA_W-1:0]        rs2_data_q [N];

    // slot view after this cycle's release, commit, dispatch and wakeup
    logic [N-1:0]             occ_d, iss_d, cmt_d, rs1_rdy_d, rs2_rdy_d, sgn_d;
    rv_op_pkg::ls_dir_e       dir_d [N];
    mem_access_pkg::acc_len_e len_d [N];
    logic [IMM_W-1:0]         imm_d [N];
    logic [TAG_W-1:0]         rs1_tag_d [N];
    logic [TAG_W-1:0]         rs2_tag_d [N];
    logic [DATA_W-1:0]        rs1_data_d [N];
    logic [DATA_W-1:0]        rs2_data_d [N];

    // execute and own load results
    logic [1:0]               bc_en;
    logic [TAG_W-1:0]         bc_tag [2];
    logic [DATA_W-1:0]        bc_data [2];

    logic                     st_hit, ld_hit;
    logic [TAG_W-1:0]         st_sel, ld_sel, sel;
    logic [DATA_W-1:0]        sel_off;
    logic [CNT_W-1:0]         cnt;

    assign bc_en      = {rsp_en, ex_en};
    assign bc_tag[0]  = ex_tag;
    assign bc_tag[1]  = rsp_tag;
    assign bc_data[0] = ex_data;
    assign bc_data[1] = rsp_data;

    always_comb begin
        occ_d      = occ_q;
        iss_d      = iss_q;
        cmt_d      = cmt_q;
        rs1_rdy_d  = rs1_rdy_q;
        rs2_rdy_d  = rs2_rdy_q;
        sgn_d      = sgn_q;
        dir_d      = dir_q;
        len_d      = len_q;
        imm_d      = imm_q;
        rs1_tag_d  = rs1_tag_q;
        rs2_tag_d  = rs2_tag_q;
        rs1_data_d = rs1_data_q;
        rs2_data_d = rs2_data_q;
        if (rsp_en) begin
            occ_d[rsp_tag] = 1'b0;
            iss_d[rsp_tag] = 1'b0;
        end
        if (commit_en) begin
            cmt_d[commit_tag] = 1'b1;
        end
        if (ent_en) begin
            occ_d[ent_tag]      = 1'b1;
            iss_d[ent_tag]      = 1'b0;
            cmt_d[ent_tag]      = 1'b0;
            dir_d[ent_tag]      = ent_dir;
            len_d[ent_tag]      = ent_len;
            sgn_d[ent_tag]      = ent_signed;
            imm_d[ent_tag]      = ent_imm;
            rs1_tag_d[ent_tag]  = ent_rs1_tag;
            rs1_data_d[ent_tag] = ent_rs1_data;
            rs1_rdy_d[ent_tag]  = ent_rs1_rdy;
            rs2_tag_d[ent_tag]  = ent_rs2_tag;
            rs2_data_d[ent_tag] = ent_rs2_data;
            rs2_rdy_d[ent_tag]  = ent_rs2_rdy;
        end
        // the entry being written snoops too
        for (int b = 0; b < 2; b++) begin
            for (int i = 1; i < N; i++) begin
                if (bc_en[b] && occ_d[i] && !rs1_rdy_d[i] && rs1_tag_d[i] == bc_tag[b]) begin
                    rs1_rdy_d[i]  = 1'b1;
                    rs1_data_d[i] = bc_data[b];
                end
                if (bc_en[b] && occ_d[i] && !rs2_rdy_d[i] && rs2_tag_d[i] == bc_tag[b]) begin
                    rs2_rdy_d[i]  = 1'b1;
                    rs2_data_d[i] = bc_data[b];
                end
            end
        end
    end

    // lowest tag wins, committed stores before loads
    always_comb begin
        st_hit = 1'b0;
        st_sel = '0;
        ld_hit = 1'b0;
        ld_sel = '0;
        for (int i = N - 1; i >= 1; i--) begin
            if (occ_d[i] && dir_d[i] == rv_op_pkg::dir_store && cmt_d[i]
                    && rs1_rdy_d[i] && rs2_rdy_d[i]) begin
                st_hit = 1'b1;
                st_sel = TAG_W'(i);
            end
            if (occ_d[i] && dir_d[i] == rv_op_pkg::dir_load && !iss_d[i] && rs1_rdy_d[i]) begin
                ld_hit = 1'b1;
                ld_sel = TAG_W'(i);
            end
        end
        sel     = st_hit ? st_sel : ld_sel;
        sel_off = {{(DATA_W - IMM_W){imm_d[sel][IMM_W-1]}}, imm_d[sel]};
    end

    always_comb begin
        cnt = CNT_W'(ent_en);
        for (int i = 0; i < N; i++) begin
            cnt = cnt + CNT_W'(occ_q[i]);
        end
    end

    assign full = (cnt >= CNT_W'(FULL_AT));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            occ_q     <= '0;
            iss_q     <= '0;
            cmt_q     <= '0;
            rs1_rdy_q <= '0;
            rs2_rdy_q <= '0;
            req_en    <= 1'b0;
        end else begin
            occ_q     <= occ_d;
            iss_q     <= iss_d;
            cmt_q     <= cmt_d;
            rs1_rdy_q <= rs1_rdy_d;
            rs2_rdy_q <= rs2_rdy_d;
            req_en    <= st_hit || ld_hit;
            // a store leaves on its request, a load waits for its response
            if (st_hit) begin
                occ_q[st_sel] <= 1'b0;
                cmt_q[st_sel] <= 1'b0;
            end else if (ld_hit) begin
                iss_q[ld_sel] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        sgn_q      <= sgn_d;
        dir_q      <= dir_d;
        len_q      <= len_d;
        imm_q      <= imm_d;
        rs1_tag_q  <= rs1_tag_d;
        rs2_tag_q  <= rs2_tag_d;
        rs1_data_q <= rs1_data_d;
        rs2_data_q <= rs2_data_d;
        req_dir    <= dir_d[sel];
        req_len    <= len_d[sel];
        req_signed <= sgn_d[sel];
        req_addr   <= rs1_data_d[sel] + sel_off;
        req_wdata  <= rs2_data_d[sel];
        req_tag    <= sel;
    end

endmodule

//--- src/ls_dispatch.sv
`timescale 1ns/10ps
`include "lsq_macros.svh"

module ls_dispatch (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     disp_en,
    input  rv_op_pkg::ls_op_e        disp_op,
    input  logic [`LSQ_IMM_W-1:0]    disp_imm,
    input  logic [`LSQ_TAG_W-1:0]    disp_tag,
    input  logic [`LSQ_TAG_W-1:0]    disp_rs1_tag,
    input  logic [`LSQ_DATA_W-1:0]   disp_rs1_data,
    input  logic [`LSQ_TAG_W-1:0]    disp_rs2_tag,
    input  logic [`LSQ_DATA_W-1:0]   disp_rs2_data,
    output logic                     ent_en,
    output logic [`LSQ_TAG_W-1:0]    ent_tag,
    output rv_op_pkg::ls_dir_e       ent_dir,
    output mem_access_pkg::acc_len_e ent_len,
    output logic                     ent_signed,
    output logic [`LSQ_IMM_W-1:0]    ent_imm,
    output logic [`LSQ_TAG_W-1:0]    ent_rs1_tag,
    output logic [`LSQ_DATA_W-1:0]   ent_rs1_data,
    output logic                     ent_rs1_rdy,
    output logic [`LSQ_TAG_W-1:0]    ent_rs2_tag,
    output logic [`LSQ_DATA_W-1:0]   ent_rs2_data,
    output logic                     ent_rs2_rdy
);
    logic                     is_mem;
    logic                     dec_signed;
    rv_op_pkg::ls_dir_e       dec_dir;
    mem_access_pkg::acc_len_e dec_len;

    always_comb begin
        is_mem     = 1'b1;
        dec_dir    = rv_op_pkg::dir_load;
        dec_len    = mem_access_pkg::len_word;
        dec_signed = 1'b1;
        case (disp_op)
            rv_op_pkg::op_lb: dec_len = mem_access_pkg::len_byte;
            rv_op_pkg::op_lh: dec_len = mem_access_pkg::len_half;
            rv_op_pkg::op_lw: dec_len = mem_access_pkg::len_word;
            rv_op_pkg::op_lbu: begin
                dec_len    = mem_access_pkg::len_byte;
                dec_signed = 1'b0;
            end
            rv_op_pkg::op_lhu: begin
                dec_len    = mem_access_pkg::len_half;
                dec_signed = 1'b0;
            end
            rv_op_pkg::op_sb: begin
                dec_dir = rv_op_pkg::dir_store;
                dec_len = mem_access_pkg::len_byte;
            end
            rv_op_pkg::op_sh: begin
                dec_dir = rv_op_pkg::dir_store;
                dec_len = mem_access_pkg::len_half;
            end
            rv_op_pkg::op_sw: dec_dir = rv_op_pkg::dir_store;
            // anything else belongs to another unit
            default: is_mem = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ent_en <= 1'b0;
        end else begin
            ent_en <= disp_en && is_mem;
        end
    end

    always_ff @(posedge clk) begin
        ent_tag      <= disp_tag;
        ent_dir      <= dec_dir;
        ent_len      <= dec_len;
        ent_signed   <= dec_signed;
        ent_imm      <= disp_imm;
        ent_rs1_tag  <= disp_rs1_tag;
        ent_rs1_data <= disp_rs1_data;
        ent_rs1_rdy  <= (disp_rs1_tag == '0);
        ent_rs2_tag  <= disp_rs2_tag;
        ent_rs2_data <= disp_rs2_data;
        // loads never read rs2
        ent_rs2_rdy  <= (dec_dir == rv_op_pkg::dir_load) || (disp_rs2_tag == '0);
    end

endmodule

//--- src/ls_unit_top.sv
`timescale 1ns/10ps
`include "lsq_macros.svh"

module ls_unit_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   disp_en,
    input  rv_op_pkg::ls_op_e      disp_op,
    input  logic [`LSQ_IMM_W-1:0]  disp_imm,
    input  logic [`LSQ_TAG_W-1:0]  disp_tag,
    input  logic [`LSQ_TAG_W-1:0]  disp_rs1_tag,
    input  logic [`LSQ_DATA_W-1:0] disp_rs1_data,
    input  logic [`LSQ_TAG_W-1:0]  disp_rs2_tag,
    input  logic [`LSQ_DATA_W-1:0] disp_rs2_data,
    input  logic                   ex_en,
    input  logic [`LSQ_TAG_W-1:0]  ex_tag,
    input  logic [`LSQ_DATA_W-1:0] ex_data,
    input  logic                   commit_en,
    input  logic [`LSQ_TAG_W-1:0]  commit_tag,
    output logic                   cdb_en,
    output logic [`LSQ_TAG_W-1:0]  cdb_tag,
    output logic [`LSQ_DATA_W-1:0] cdb_data,
    output logic                   full
);
    logic                     ent_en, ent_signed, ent_rs1_rdy, ent_rs2_rdy;
    logic [`LSQ_TAG_W-1:0]    ent_tag, ent_rs1_tag, ent_rs2_tag;
    logic [`LSQ_DATA_W-1:0]   ent_rs1_data, ent_rs2_data;
    logic [`LSQ_IMM_W-1:0]    ent_imm;
    rv_op_pkg::ls_dir_e       ent_dir, req_dir;
    mem_access_pkg::acc_len_e ent_len, req_len;
    logic                     req_en, req_signed;
    logic [`LSQ_DATA_W-1:0]   req_addr, req_wdata;
    logic [`LSQ_TAG_W-1:0]    req_tag;

    ls_dispatch u_dispatch (
        .clk, .arst_n,
        .disp_en, .disp_op, .disp_imm, .disp_tag,
        .disp_rs1_tag, .disp_rs1_data, .disp_rs2_tag, .disp_rs2_data,
        .ent_en, .ent_tag, .ent_dir, .ent_len, .ent_signed, .ent_imm,
        .ent_rs1_tag, .ent_rs1_data, .ent_rs1_rdy,
        .ent_rs2_tag, .ent_rs2_data, .ent_rs2_rdy
    );

    // load results wake the buffer and leave as the cdb
    ls_buffer u_buffer (
        .clk, .arst_n,
        .ent_en, .ent_tag, .ent_dir, .ent_len, .ent_signed, .ent_imm,
        .ent_rs1_tag, .ent_rs1_data, .ent_rs1_rdy,
        .ent_rs2_tag, .ent_rs2_data, .ent_rs2_rdy,
        .ex_en, .ex_tag, .ex_data,
        .commit_en, .commit_tag,
        .rsp_en(cdb_en), .rsp_tag(cdb_tag), .rsp_data(cdb_data),
        .req_en, .req_dir, .req_len, .req_signed, .req_addr, .req_wdata, .req_tag,
        .full
    );

    data_mem u_mem (
        .clk, .arst_n,
        .req_en, .req_dir, .req_len, .req_signed, .req_addr, .req_wdata, .req_tag,
        .rsp_en(cdb_en), .rsp_tag(cdb_tag), .rsp_data(cdb_data)
    );

endmodule

//--- src/lsq_macros.svh
`ifndef LSQ_MACROS_SVH
`define LSQ_MACROS_SVH

// destination tag, tag 0 means no dependency
`define LSQ_TAG_W 4
// slots indexed by tag, slot 0 never holds an entry
`define LSQ_ENTRIES 16

// data and byte address width
`define LSQ_DATA_W 32
// signed offset from the instruction
`define LSQ_IMM_W 12

// word depth of the data memory
`define LSQ_MEM_WORDS 256
// request to response, in cycles
`define LSQ_MEM_LAT 2

`endif

//--- src/mem_access_pkg.sv
package mem_access_pkg;

    // access size of one memory request
    typedef enum logic [1:0] {
        len_byte = 2'd0,
        len_half = 2'd1,
        len_word = 2'd2
    } acc_len_e;

endpackage

//--- src/rv_op_pkg.sv
package rv_op_pkg;

    // rv32i memory opcodes, same encoding as dispatch
    typedef enum logic [3:0] {
        op_lb    = 4'd0,
        op_lh    = 4'd1,
        op_lw    = 4'd2,
        op_lbu   = 4'd3,
        op_lhu   = 4'd4,
        op_sb    = 4'd5,
        op_sh    = 4'd6,
        op_sw    = 4'd7,
        op_other = 4'd15
    } ls_op_e;

    typedef enum logic {
        dir_load  = 1'b0,
        dir_store = 1'b1
    } ls_dir_e;

endpackage
